// ==== rtefi_lite.f ====
logic/rtefi_pkg.sv
logic/rtefi_config.sv
logic/rx_crc_check.sv
logic/rx_scanner.sv
logic/pbuf_writer.sv
logic/rtefi_rx_top.sv
tb/rtefi_rx_props.sv
tb/rtefi_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the receive testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module rtefi_rx_tb -Mdir obj_dir -o rtefi_rx_sim \
	-f rtefi_lite.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rtefi_rx_sim
if [ $? -ne 0 ]; then
	echo "simulation ended with an error"
	exit 1
fi

exit 0

// ==== tb/rtefi_rx_tb.sv ====
// Random frame testbench that checks the receive top's status and buffer against a frame model
`timescale 1ns/1ns
`default_nettype none

module rtefi_rx_tb;

	localparam int MAX_LEN = 128;
	localparam int WAIT_MAX = 200;
	localparam int N_KINDS = 10;
	localparam int N_ROUNDS = 50;

	logic rx_clk;
	logic rst_n;
	logic [7:0] rxd;
	logic rx_dv, rx_er, enable_rx;
	logic [3:0] config_a;
	logic [7:0] config_d;
	logic config_s, config_p;
	logic [rtefi_pkg::PAW-1:0] rd_addr;
	logic rx_release;
	logic [7:0] status_vec;
	logic [rtefi_pkg::LEN_W-1:0] status_len;
	logic status_accept, status_valid, buf_full, rx_mon;
	logic [8:0] rd_data;

	// Model copy of the configuration and the buffer state
	integer seed;
	logic [47:0] m_mac;
	logic [31:0] m_ip;
	logic [15:0] m_port [8];
	logic m_full;
	// Frame under test as body bytes with the FCS
	logic [7:0] frm [MAX_LEN];
	int frm_len;
	int er_at;
	// Copy of the frame that should sit in the buffer
	logic [7:0] held [MAX_LEN];
	int held_len;
	logic [7:0] exp_vec;
	logic [10:0] exp_len;
	logic exp_acc;
	string test_name;

	rtefi_rx_top dut_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er), .enable_rx(enable_rx),
		.config_a(config_a), .config_d(config_d), .config_s(config_s), .config_p(config_p),
		.rd_addr(rd_addr), .rx_release(rx_release),
		.status_vec(status_vec), .status_len(status_len), .status_accept(status_accept),
		.status_valid(status_valid), .buf_full(buf_full), .rd_data(rd_data), .rx_mon(rx_mon)
	);

	initial rx_clk = 1'b0;
	always #10 rx_clk = ~rx_clk;

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Bit-serial CRC-32 with data entering LSB first
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ 32'hEDB88320;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else begin
			$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
			$display("sim failed");
			$fatal(1, "value check failed");
		end
	endtask

	// Appends the FCS with its low byte first
	task automatic seal_fcs();
		logic [31:0] crc;
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < frm_len - 4; i++)
			crc = crc_step(crc, frm[i]);
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			frm[frm_len - 4 + i] = crc[8 * i +: 8];
	endtask

	// Frame kinds are 0 UDP hit, 1 UDP random port, 2 ARP broadcast, 3 ARP other IP,
	// 4 other ethertype, 5 short, 6 bad CRC, 7 rx_er, 8 wrong MAC, 9 ARP unicast
	task automatic build_frame(input int kind);
		logic [15:0] port;
		int body;
		int idx;
		port = m_port[0];
		er_at = -1;
		if (kind == 5)
			body = 10 + int'(rand_byte() % 8'd32);
		else
			body = 42 + int'(rand_byte() % 8'd41);
		frm_len = body + 4;
		for (int i = 0; i < body; i++)
			frm[i] = rand_byte();
		for (int i = 0; i < 6; i++)
			frm[i] = (kind == 2) ? 8'hFF : m_mac[47 - 8 * i -: 8];
		if (kind == 8)
			frm[5] = ~frm[5];
		if (kind == 2 || kind == 3 || kind == 9) begin
			frm[12] = 8'h08;
			frm[13] = 8'h06;
			// Target protocol address
			for (int i = 0; i < 4; i++)
				frm[38 + i] = m_ip[31 - 8 * i -: 8];
			if (kind == 3)
				frm[41] = ~frm[41];
		end else if (kind == 4) begin
			// IPv6 ethertype
			frm[12] = 8'h86;
			frm[13] = 8'hDD;
		end else if (kind != 5) begin
			if (kind == 0)
				port = m_port[rand_byte() % 8'd4];
			if (kind == 1) begin
				port = {rand_byte(), rand_byte()};
				if (rand_byte() < 8'd96)
					port = 16'd0;
			end
			frm[12] = 8'h08;
			frm[13] = 8'h00;
			frm[14] = 8'h45;
			frm[23] = 8'd17;
			for (int i = 0; i < 4; i++)
				frm[30 + i] = m_ip[31 - 8 * i -: 8];
			frm[36] = port[15:8];
			frm[37] = port[7:0];
		end
		seal_fcs();
		idx = int'(rand_byte()) % frm_len;
		// A single bit flip is always caught by the CRC
		if (kind == 6)
			frm[idx] = frm[idx] ^ 8'h10;
		if (kind == 7)
			er_at = idx;
	endtask

	// Rewrites UDP destination port and IP and reseals the frame
	task automatic set_udp(input logic [15:0] port, input logic [31:0] ip);
		for (int i = 0; i < 4; i++)
			frm[30 + i] = ip[31 - 8 * i -: 8];
		frm[36] = port[15:8];
		frm[37] = port[7:0];
		seal_fcs();
	endtask

	task automatic predict(input logic full_at_sof);
		logic [31:0] crc;
		logic crc_good, mac_eq, bcast, mac_good, ip_good, hit;
		logic [1:0] cat;
		logic [2:0] sel;
		logic [15:0] dp;
		int n;
		n = frm_len;
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < n - 4; i++)
			crc = crc_step(crc, frm[i]);
		crc_good = {frm[n - 1], frm[n - 2], frm[n - 3], frm[n - 4]} == ~crc && er_at < 0;
		mac_eq = 1'b1;
		bcast = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (frm[i] != m_mac[47 - 8 * i -: 8])
				mac_eq = 1'b0;
			if (frm[i] != 8'hFF)
				bcast = 1'b0;
		end
		if (n < 46)
			cat = rtefi_pkg::CAT_NONE;
		else if ({frm[12], frm[13]} == 16'h0806)
			cat = rtefi_pkg::CAT_ARP;
		else if ({frm[12], frm[13]} == 16'h0800 && frm[14] == 8'h45 && frm[23] == 8'd17)
			cat = rtefi_pkg::CAT_UDP;
		else
			cat = rtefi_pkg::CAT_OTHER;
		// First nonzero slot holding the port
		dp = (n < 46) ? 16'd0 : {frm[36], frm[37]};
		hit = 1'b0;
		sel = 3'd0;
		for (int i = 0; i < 8; i++) begin
			if (!hit && m_port[i] != 16'd0 && m_port[i] == dp) begin
				hit = 1'b1;
				sel = 3'(i);
			end
		end
		mac_good = mac_eq || (bcast && cat == rtefi_pkg::CAT_ARP);
		if (cat == rtefi_pkg::CAT_ARP)
			ip_good = {frm[38], frm[39], frm[40], frm[41]} == m_ip;
		else if (cat == rtefi_pkg::CAT_UDP)
			ip_good = {frm[30], frm[31], frm[32], frm[33]} == m_ip && hit;
		else
			ip_good = 1'b0;
		exp_vec = {(cat == rtefi_pkg::CAT_UDP && hit) ? sel : 3'd0, cat, ip_good,
			mac_good, crc_good};
		exp_len = 11'(n);
		exp_acc = !full_at_sof && crc_good && mac_good && ip_good &&
			(cat == rtefi_pkg::CAT_ARP || cat == rtefi_pkg::CAT_UDP);
	endtask

	// Sends preamble, SFD and body with one byte per falling edge
	task automatic send_frame();
		for (int i = 0; i < 8; i++) begin
			@(negedge rx_clk);
			rx_dv = 1'b1;
			rx_er = 1'b0;
			rxd = (i == 7) ? 8'hD5 : 8'h55;
		end
		for (int i = 0; i < frm_len; i++) begin
			@(negedge rx_clk);
			// rx_dv was already high at the previous edge
			compare("rx_mon high", 1, rx_mon);
			rxd = frm[i];
			rx_er = i == er_at;
		end
		@(negedge rx_clk);
		rx_dv = 1'b0;
		rx_er = 1'b0;
		rxd = 8'h00;
	endtask

	task automatic check_frame();
		int t;
		predict(m_full);
		send_frame();
		t = 0;
		while (!status_valid && t < WAIT_MAX) begin
			@(negedge rx_clk);
			t++;
		end
		assert (status_valid) else begin
			$display("Timeout in %s, no status_valid after the frame", test_name);
			$display("sim failed");
			$fatal(1, "status strobe missing");
		end
		// Two edges after the edge that first samples rx_dv low
		compare("status latency", 3, t);
		compare("rx_mon low", 0, rx_mon);
		compare("status_vec", exp_vec, status_vec);
		compare("status_len", exp_len, status_len);
		compare("status_accept", exp_acc, status_accept);
		if (exp_acc) begin
			m_full = 1'b1;
			held_len = frm_len;
			for (int i = 0; i < frm_len; i++)
				held[i] = frm[i];
		end
		compare("buf_full", m_full, buf_full);
	endtask

	// Host read with data one cycle after the address
	task automatic read_back();
		for (int a = 0; a < held_len; a++) begin
			@(negedge rx_clk);
			rd_addr = 11'(a);
			@(negedge rx_clk);
			compare($sformatf("rd_data[%0d]", a), {a == 0, held[a]}, rd_data);
		end
	endtask

	task automatic release_buf();
		@(negedge rx_clk);
		rx_release = 1'b1;
		@(negedge rx_clk);
		rx_release = 1'b0;
		m_full = 1'b0;
		compare("buf_full after release", m_full, buf_full);
	endtask

	task automatic write_cfg(input logic port_bank, input logic [3:0] a, input logic [7:0] d);
		@(negedge rx_clk);
		config_a = a;
		config_d = d;
		config_s = !port_bank;
		config_p = port_bank;
		@(negedge rx_clk);
		config_s = 1'b0;
		config_p = 1'b0;
	endtask

	initial begin
		logic [7:0] r_hi;
		logic [7:0] r_lo;
		logic [15:0] new_port;
		logic [15:0] old_port;
		logic [31:0] old_ip;
		seed = 32'h82a0;
		rst_n = 1'b0;
		rxd = 8'h00;
		rx_dv = 1'b0;
		rx_er = 1'b0;
		enable_rx = 1'b0;
		config_a = 4'd0;
		config_d = 8'd0;
		config_s = 1'b0;
		config_p = 1'b0;
		rd_addr = '0;
		rx_release = 1'b0;
		m_mac = rtefi_pkg::DEF_MAC;
		m_ip = {8'd192, 8'd168, 8'd7, 8'd4};
		m_port = '{16'd7, 16'd801, 16'd802, 16'd803, 16'd0, 16'd0, 16'd0, 16'd0};
		m_full = 1'b0;
		held_len = 0;
		repeat (10) @(negedge rx_clk);
		rst_n = 1'b1;
		enable_rx = 1'b1;
		test_name = "reset";
		compare("buf_full", 0, buf_full);
		compare("status_valid", 0, status_valid);
		compare("status_accept", 0, status_accept);
		compare("rx_mon", 0, rx_mon);

		// Every frame kind in turn with random contents
		for (int r = 0; r < N_ROUNDS; r++) begin
			test_name = $sformatf("round%0d_kind%0d", r, r % N_KINDS);
			build_frame(r % N_KINDS);
			check_frame();
			if (exp_acc) begin
				read_back();
				release_buf();
			end
		end

		// Second good frame while the first one is held
		test_name = "full_first";
		build_frame(0);
		check_frame();
		compare("status_accept", 1, status_accept);
		test_name = "full_second";
		build_frame(0);
		check_frame();
		compare("good bits", 3'b111, status_vec[2:0]);
		read_back();
		release_buf();

		// Move slot 3 and the last IP byte at run time
		test_name = "config_write";
		r_hi = rand_byte();
		r_lo = rand_byte();
		new_port = 16'd1000 + {2'b00, r_hi[5:0], r_lo};
		old_port = m_port[3];
		old_ip = m_ip;
		write_cfg(1'b1, 4'd6, new_port[15:8]);
		write_cfg(1'b1, 4'd7, new_port[7:0]);
		write_cfg(1'b0, 4'd9, old_ip[7:0] ^ {r_hi[7:1], 1'b1});
		m_port[3] = new_port;
		m_ip[7:0] = old_ip[7:0] ^ {r_hi[7:1], 1'b1};

		test_name = "new_port_new_ip";
		build_frame(0);
		set_udp(new_port, m_ip);
		check_frame();
		compare("status_accept", 1, status_accept);
		compare("udp slot", 3, status_vec[7:5]);
		read_back();
		release_buf();
		test_name = "old_port";
		build_frame(0);
		set_udp(old_port, m_ip);
		check_frame();
		compare("status_accept", 0, status_accept);
		test_name = "old_ip";
		build_frame(0);
		set_udp(new_port, old_ip);
		check_frame();
		compare("status_accept", 0, status_accept);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/rtefi_rx_props.sv ====
// Concurrent checks on the status strobe and buffer occupancy, bound into the receive top
`timescale 1ns/1ns
`default_nettype none

module rtefi_rx_props (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic status_valid,
	input wire logic status_accept,
	input wire logic buf_full,
	input wire logic mem_we
);

	// Status strobe is a single-cycle pulse
	a_valid_pulse: assert property (@(posedge rx_clk) disable iff (!rst_n)
		status_valid |=> !status_valid)
		else $error("status_valid stayed high for two cycles");

	// Buffer only fills on an accepted status
	a_full_rise: assert property (@(posedge rx_clk) disable iff (!rst_n)
		$rose(buf_full) |-> status_valid && status_accept)
		else $error("buf_full rose without an accepted status");

	// A held frame is never overwritten
	a_no_write_full: assert property (@(posedge rx_clk) disable iff (!rst_n)
		!(mem_we && buf_full))
		else $error("packet buffer written while buf_full is high");

endmodule

bind rtefi_rx_top rtefi_rx_props props_i (
	.rx_clk(rx_clk),
	.rst_n(rst_n),
	.status_valid(status_valid),
	.status_accept(status_accept),
	.buf_full(buf_full),
	.mem_we(mem_we)
);

`default_nettype wire

// ==== logic/rtefi_rx_top.sv ====
// Top of the receive front end, GMII in, packet buffer and host read port out
`timescale 1ns/1ns
`default_nettype none

module rtefi_rx_top (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic [7:0] rxd,
	input wire logic rx_dv,
	input wire logic rx_er,
	input wire logic enable_rx,
	input wire logic [3:0] config_a,
	input wire logic [7:0] config_d,
	input wire logic config_s,
	input wire logic config_p,
	input wire logic [rtefi_pkg::PAW-1:0] rd_addr,
	input wire logic rx_release,
	output logic [7:0] status_vec,
	output logic [rtefi_pkg::LEN_W-1:0] status_len,
	output logic status_accept,
	output logic status_valid,
	output logic buf_full,
	output logic [8:0] rd_data,
	output logic rx_mon
);

	logic [7:0] eth_d;
	logic eth_dv, eth_er;
	logic [47:0] cfg_mac;
	logic [31:0] cfg_ip;
	logic [15:0] dport;
	logic udp_hit;
	logic [2:0] udp_sel;
	logic crc_clear, crc_byte_s, crc_ok;
	logic [7:0] crc_d;
	logic [7:0] frame_d;
	logic frame_s, frame_sof, frame_end;
	logic [rtefi_pkg::PAW-1:0] mem_a;
	logic [8:0] mem_d;
	logic mem_we;
	// One frame of 9-bit entries, bit 8 marks the first byte
	logic [8:0] pbuf [1 << rtefi_pkg::PAW];

	// Input registers, intended to land in the pads
	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			eth_dv <= 1'b0;
			eth_er <= 1'b0;
		end else begin
			eth_dv <= rx_dv;
			eth_er <= rx_er;
		end
	end

	always_ff @(posedge rx_clk) begin
		eth_d <= rxd;
	end

	assign rx_mon = eth_dv;

	// Write from the writer, synchronous read for the host
	always_ff @(posedge rx_clk) begin
		if (mem_we)
			pbuf[mem_a] <= mem_d;
		rd_data <= pbuf[rd_addr];
	end

	rtefi_config config_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.config_a(config_a), .config_d(config_d),
		.config_s(config_s), .config_p(config_p),
		.dport(dport), .cfg_mac(cfg_mac), .cfg_ip(cfg_ip),
		.udp_hit(udp_hit), .udp_sel(udp_sel)
	);

	rx_scanner scan_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.eth_d(eth_d), .eth_dv(eth_dv), .eth_er(eth_er), .enable_rx(enable_rx),
		.cfg_mac(cfg_mac), .cfg_ip(cfg_ip), .udp_hit(udp_hit), .udp_sel(udp_sel),
		.dport(dport),
		.crc_clear(crc_clear), .crc_byte_s(crc_byte_s), .crc_d(crc_d), .crc_ok(crc_ok),
		.frame_d(frame_d), .frame_s(frame_s), .frame_sof(frame_sof), .frame_end(frame_end),
		.status_vec(status_vec), .status_len(status_len), .status_valid(status_valid)
	);

	rx_crc_check crc_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.crc_clear(crc_clear), .crc_byte_s(crc_byte_s), .crc_d(crc_d), .crc_ok(crc_ok)
	);

	pbuf_writer write_i (
		.rx_clk(rx_clk), .rst_n(rst_n),
		.frame_d(frame_d), .frame_s(frame_s), .frame_sof(frame_sof), .frame_end(frame_end),
		.status_vec(status_vec), .status_valid(status_valid), .rx_release(rx_release),
		.mem_a(mem_a), .mem_d(mem_d), .mem_we(mem_we),
		.status_accept(status_accept), .buf_full(buf_full)
	);

endmodule

`default_nettype wire

// ==== logic/pbuf_writer.sv ====
// Packet buffer writer, stores one frame with a start marker and decides acceptance
`timescale 1ns/1ns
`default_nettype none

module pbuf_writer (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic [7:0] frame_d,
	input wire logic frame_s,
	input wire logic frame_sof,
	input wire logic frame_end,
	input wire logic [7:0] status_vec,
	input wire logic status_valid,
	input wire logic rx_release,
	output logic [rtefi_pkg::PAW-1:0] mem_a,
	output logic [8:0] mem_d,
	output logic mem_we,
	output logic status_accept,
	output logic buf_full
);

	logic store_q;
	logic store_now;
	logic accept_q;
	logic accept_now;
	rtefi_pkg::rx_cat_e cat;

	// Decision at the first byte uses the live buf_full
	assign store_now = frame_sof ? !buf_full : store_q;

	assign cat = rtefi_pkg::rx_cat_e'(status_vec[rtefi_pkg::ST_CAT_LO +: 2]);
	// UDP port hit is already folded into the IP bit by the scanner
	assign accept_now = store_q &&
		status_vec[rtefi_pkg::ST_CRC_OK] &&
		status_vec[rtefi_pkg::ST_MAC_OK] &&
		status_vec[rtefi_pkg::ST_IP_OK] &&
		(cat == rtefi_pkg::CAT_ARP || cat == rtefi_pkg::CAT_UDP);

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			store_q <= 1'b0;
			mem_we <= 1'b0;
			accept_q <= 1'b0;
			buf_full <= 1'b0;
		end else begin
			if (frame_sof)
				store_q <= !buf_full;
			mem_we <= frame_s && store_now;
			// Frame end leads status_valid by one cycle, so buf_full rises with it
			if (frame_end) begin
				accept_q <= accept_now;
				if (accept_now)
					buf_full <= 1'b1;
			end else if (rx_release) begin
				buf_full <= 1'b0;
			end
		end
	end

	// Address restarts at every frame, first byte tagged in bit 8
	always_ff @(posedge rx_clk) begin
		if (frame_s) begin
			mem_a <= frame_sof ? '0 : mem_a + 1'b1;
			mem_d <= {frame_sof, frame_d};
		end
	end

	// Held decision is exposed only on the status strobe
	assign status_accept = status_valid && accept_q;

endmodule

`default_nettype wire

// ==== logic/rx_scanner.sv ====
// Receive scanner, strips the preamble, matches header fields and reports frame status
`timescale 1ns/1ns
`default_nettype none

module rx_scanner (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic [7:0] eth_d,
	input wire logic eth_dv,
	input wire logic eth_er,
	input wire logic enable_rx,
	input wire logic [47:0] cfg_mac,
	input wire logic [31:0] cfg_ip,
	input wire logic udp_hit,
	input wire logic [2:0] udp_sel,
	output logic [15:0] dport,
	output logic crc_clear,
	output logic crc_byte_s,
	output logic [7:0] crc_d,
	input wire logic crc_ok,
	output logic [7:0] frame_d,
	output logic frame_s,
	output logic frame_sof,
	output logic frame_end,
	output logic [7:0] status_vec,
	output logic [rtefi_pkg::LEN_W-1:0] status_len,
	output logic status_valid
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_PREAMBLE,
		S_BODY,
		S_DRAIN
	} scan_state_e;

	scan_state_e state;
	logic [rtefi_pkg::LEN_W-1:0] cnt;
	logic dv_q;
	logic er_seen;
	logic start;
	logic sfd_hit;
	// Per-frame match flags
	logic mac_match, mac_bcast, ip4_match, arp_match, ver_ok, proto_udp;
	logic [15:0] etype;
	logic [7:0] mac_byte;
	logic [7:0] ip_byte;
	logic [1:0] ip_k;
	rtefi_pkg::rx_cat_e cat_now;
	logic mac_ok, ip_ok;
	logic [7:0] next_vec;

	// Only a rising eth_dv starts a frame, so a frame cut by enable_rx is skipped whole
	assign start = eth_dv && !dv_q && enable_rx;
	assign sfd_hit = eth_dv && eth_d == rtefi_pkg::ETH_SFD &&
		(state == S_PREAMBLE || (state == S_IDLE && start));

	// Body bytes go to both the CRC checker and the buffer writer
	assign frame_s = state == S_BODY && eth_dv;
	assign frame_d = eth_d;
	assign frame_sof = frame_s && cnt == '0;
	assign frame_end = state == S_DRAIN;
	assign crc_clear = sfd_hit;
	assign crc_byte_s = frame_s;
	assign crc_d = eth_d;

	// Expected MAC byte for offsets 0 to 5
	assign mac_byte = cfg_mac[47 - 8 * cnt[2:0] -: 8];
	// IPv4 destination and ARP target share the same word alignment
	assign ip_k = cnt[1:0] - rtefi_pkg::OFF_IP_DST[1:0];
	assign ip_byte = cfg_ip[31 - 8 * ip_k -: 8];

	// Control path
	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
			dv_q <= 1'b0;
			er_seen <= 1'b0;
			status_valid <= 1'b0;
		end else begin
			dv_q <= eth_dv;
			status_valid <= state == S_DRAIN;
			if (eth_dv && eth_er)
				er_seen <= 1'b1;
			case (state)
				S_IDLE: begin
					if (start) begin
						er_seen <= eth_er;
						cnt <= '0;
						state <= sfd_hit ? S_BODY : S_PREAMBLE;
					end
				end
				S_PREAMBLE: begin
					// Any byte other than the SFD counts as preamble
					if (!eth_dv)
						state <= S_IDLE;
					else if (sfd_hit)
						state <= S_BODY;
				end
				S_BODY: begin
					if (eth_dv)
						cnt <= cnt + 1'b1;
					else
						state <= S_DRAIN;
				end
				// One cycle to present status, then the pulse
				default: state <= S_IDLE;
			endcase
		end
	end

	// Field compares, all keyed on the offset of the byte now on eth_d
	always_ff @(posedge rx_clk) begin
		if (sfd_hit) begin
			mac_match <= 1'b1;
			mac_bcast <= 1'b1;
			ip4_match <= 1'b1;
			arp_match <= 1'b1;
		end
		if (frame_s) begin
			if (cnt < 11'd6) begin
				if (eth_d != mac_byte)
					mac_match <= 1'b0;
				if (eth_d != 8'hFF)
					mac_bcast <= 1'b0;
			end
			if (cnt == rtefi_pkg::OFF_ETYPE)
				etype[15:8] <= eth_d;
			if (cnt == rtefi_pkg::OFF_ETYPE + 11'd1)
				etype[7:0] <= eth_d;
			if (cnt == rtefi_pkg::OFF_IP_VER)
				ver_ok <= eth_d == rtefi_pkg::IP_VER_IHL;
			if (cnt == rtefi_pkg::OFF_IP_PROTO)
				proto_udp <= eth_d == rtefi_pkg::PROTO_UDP;
			if (cnt >= rtefi_pkg::OFF_IP_DST && cnt < rtefi_pkg::OFF_IP_DST + 11'd4 &&
					eth_d != ip_byte)
				ip4_match <= 1'b0;
			if (cnt >= rtefi_pkg::OFF_ARP_TPA && cnt < rtefi_pkg::OFF_ARP_TPA + 11'd4 &&
					eth_d != ip_byte)
				arp_match <= 1'b0;
			if (cnt == rtefi_pkg::OFF_UDP_DPORT)
				dport[15:8] <= eth_d;
			if (cnt == rtefi_pkg::OFF_UDP_DPORT + 11'd1)
				dport[7:0] <= eth_d;
		end
		// Status is captured as eth_dv falls, crc_ok already covers the last byte
		if (state == S_BODY && !eth_dv) begin
			status_vec <= next_vec;
			status_len <= cnt;
		end
	end

	// Category and status bits
	always_comb begin
		if (cnt < rtefi_pkg::MIN_UDP_LEN)
			cat_now = rtefi_pkg::CAT_NONE;
		else if (etype == rtefi_pkg::ETYPE_ARP)
			cat_now = rtefi_pkg::CAT_ARP;
		else if (etype == rtefi_pkg::ETYPE_IPV4 && ver_ok && proto_udp)
			cat_now = rtefi_pkg::CAT_UDP;
		else
			cat_now = rtefi_pkg::CAT_OTHER;
		// Broadcast destination is only good for ARP
		mac_ok = mac_match || (mac_bcast && cat_now == rtefi_pkg::CAT_ARP);
		// For UDP the IP bit also demands a configured destination port
		case (cat_now)
			rtefi_pkg::CAT_ARP: ip_ok = arp_match;
			rtefi_pkg::CAT_UDP: ip_ok = ip4_match && udp_hit;
			default: ip_ok = 1'b0;
		endcase
		next_vec = 8'd0;
		next_vec[rtefi_pkg::ST_CRC_OK] = crc_ok && !er_seen;
		next_vec[rtefi_pkg::ST_MAC_OK] = mac_ok;
		next_vec[rtefi_pkg::ST_IP_OK] = ip_ok;
		next_vec[rtefi_pkg::ST_CAT_LO +: 2] = cat_now;
		if (cat_now == rtefi_pkg::CAT_UDP && udp_hit)
			next_vec[rtefi_pkg::ST_SEL_LO +: 3] = udp_sel;
	end

endmodule

`default_nettype wire

// ==== logic/rx_crc_check.sv ====
// Running Ethernet CRC-32 over received frame bytes, flags a good frame by its residue
`timescale 1ns/1ns
`default_nettype none

module rx_crc_check (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic crc_clear,
	input wire logic crc_byte_s,
	input wire logic [7:0] crc_d,
	output logic crc_ok
);

	logic [31:0] crc_q;
	logic [31:0] crc_next;
	logic [31:0] crc_rev;

	// Reflected polynomial, data enters LSB first
	always_comb begin
		crc_next = crc_q ^ {24'd0, crc_d};
		for (int b = 0; b < 8; b++) begin
			if (crc_next[0])
				crc_next = (crc_next >> 1) ^ 32'hEDB88320;
			else
				crc_next = crc_next >> 1;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			crc_q <= 32'hFFFFFFFF;
		end else if (crc_clear) begin
			// Preset at the SFD, ahead of the first body byte
			crc_q <= 32'hFFFFFFFF;
		end else if (crc_byte_s) begin
			crc_q <= crc_next;
		end
	end

	// Register holds the reflected residue once the FCS is absorbed
	assign crc_rev = {<<{crc_q}};
	assign crc_ok = crc_rev == rtefi_pkg::CRC_RESIDUE;

endmodule

`default_nettype wire

// ==== logic/rtefi_config.sv ====
// Run-time station MAC/IP and UDP port table with the port lookup used by the scanner
`timescale 1ns/1ns
`default_nettype none

module rtefi_config (
	input wire logic rx_clk,
	input wire logic rst_n,
	input wire logic [3:0] config_a,
	input wire logic [7:0] config_d,
	input wire logic config_s,
	input wire logic config_p,
	input wire logic [15:0] dport,
	output logic [47:0] cfg_mac,
	output logic [31:0] cfg_ip,
	output logic udp_hit,
	output logic [2:0] udp_sel
);

	logic [15:0] port_q [rtefi_pkg::N_UDP];

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			cfg_mac <= rtefi_pkg::DEF_MAC;
			cfg_ip <= rtefi_pkg::DEF_IP;
			port_q[0] <= rtefi_pkg::DEF_UDP0;
			port_q[1] <= rtefi_pkg::DEF_UDP1;
			port_q[2] <= rtefi_pkg::DEF_UDP2;
			port_q[3] <= rtefi_pkg::DEF_UDP3;
			port_q[4] <= rtefi_pkg::DEF_UDP4;
			port_q[5] <= rtefi_pkg::DEF_UDP5;
			port_q[6] <= rtefi_pkg::DEF_UDP6;
			port_q[7] <= rtefi_pkg::DEF_UDP7;
		end else begin
			// Address 0 is the first MAC byte on the wire, 6 the first IP byte
			if (config_s) begin
				if (config_a < 4'd6)
					cfg_mac[47 - 8 * config_a -: 8] <= config_d;
				else if (config_a < 4'd10)
					cfg_ip[31 - 8 * (config_a - 4'd6) -: 8] <= config_d;
			end
			// Two bytes per slot, high byte at the even address
			if (config_p) begin
				if (config_a[0])
					port_q[config_a[3:1]][7:0] <= config_d;
				else
					port_q[config_a[3:1]][15:8] <= config_d;
			end
		end
	end

	// Parallel compare, scanning downward so the lowest matching slot wins
	always_comb begin
		udp_hit = 1'b0;
		udp_sel = 3'd0;
		for (int i = rtefi_pkg::N_UDP - 1; i >= 0; i--) begin
			if (port_q[i] != 16'd0 && port_q[i] == dport) begin
				udp_hit = 1'b1;
				udp_sel = 3'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rtefi_pkg.sv ====
// Shared constants and types of the receive path, referenced by scoped names from each block
`default_nettype none

package rtefi_pkg;

	// Sizes
	localparam int PAW = 11;
	localparam int LEN_W = 11;
	localparam int N_UDP = 8;

	// Reset defaults for the station addresses
	localparam logic [47:0] DEF_MAC = 48'h12555500012d;
	// 192.168.7.4
	localparam logic [31:0] DEF_IP = {8'd192, 8'd168, 8'd7, 8'd4};
	// A port number of zero disables its slot
	localparam logic [15:0] DEF_UDP0 = 16'd7;
	localparam logic [15:0] DEF_UDP1 = 16'd801;
	localparam logic [15:0] DEF_UDP2 = 16'd802;
	localparam logic [15:0] DEF_UDP3 = 16'd803;
	localparam logic [15:0] DEF_UDP4 = 16'd0;
	localparam logic [15:0] DEF_UDP5 = 16'd0;
	localparam logic [15:0] DEF_UDP6 = 16'd0;
	localparam logic [15:0] DEF_UDP7 = 16'd0;

	// Byte offsets from the first destination MAC byte
	localparam logic [LEN_W-1:0] OFF_ETYPE = 11'd12;
	localparam logic [LEN_W-1:0] OFF_IP_VER = 11'd14;
	localparam logic [LEN_W-1:0] OFF_IP_PROTO = 11'd23;
	localparam logic [LEN_W-1:0] OFF_IP_DST = 11'd30;
	localparam logic [LEN_W-1:0] OFF_UDP_DPORT = 11'd36;
	localparam logic [LEN_W-1:0] OFF_ARP_TPA = 11'd38;
	// Shorter frames are reported as category none
	localparam logic [LEN_W-1:0] MIN_UDP_LEN = 11'd46;

	// Protocol constants
	localparam logic [7:0] ETH_SFD = 8'hD5;
	localparam logic [7:0] IP_VER_IHL = 8'h45;
	localparam logic [15:0] ETYPE_IPV4 = 16'h0800;
	localparam logic [15:0] ETYPE_ARP = 16'h0806;
	localparam logic [7:0] PROTO_UDP = 8'd17;
	// Residue in the usual MSB-first notation
	localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

	// Status vector layout
	localparam int ST_CRC_OK = 0;
	localparam int ST_MAC_OK = 1;
	localparam int ST_IP_OK = 2;
	localparam int ST_CAT_LO = 3;
	localparam int ST_SEL_LO = 5;

	typedef enum logic [1:0] {
		CAT_NONE = 2'd0,
		CAT_ARP = 2'd1,
		CAT_UDP = 2'd2,
		CAT_OTHER = 2'd3
	} rx_cat_e;

endpackage

`default_nettype wire
